// File: bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] bmem_addr_i,
    input  logic        bmem_read_i,
    output logic        bmem_ready_o,
    output logic [31:0] bmem_raddr_o,
    output logic [63:0] bmem_rdata_o,
    output logic        bmem_rvalid_o
);
    localparam logic [31:0] DATA_KEY = 32'h5A5A_5A5A;

    logic [31:0] rng;
    logic        busy;
    logic [1:0]  wait_cnt;   // cycles before ready or the next beat
    logic [1:0]  beat;
    logic [31:0] base;
    logic [31:0] beat_addr;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign beat_addr = base | {27'd0, beat, 3'd0};

    always @(posedge clk) begin
        if (rst) begin
            rng           <= 32'd10065;
            busy          <= 1'b0;
            wait_cnt      <= 2'd0;
            beat          <= 2'd0;
            base          <= 32'd0;
            bmem_ready_o  <= 1'b0;
            bmem_rvalid_o <= 1'b0;
            bmem_raddr_o  <= 32'd0;
            bmem_rdata_o  <= 64'd0;
        end else if (!busy) begin
            bmem_rvalid_o <= 1'b0;
            if (bmem_read_i && bmem_ready_o) begin
                busy         <= 1'b1;
                base         <= bmem_addr_i;
                beat         <= 2'd0;
                bmem_ready_o <= 1'b0;
                wait_cnt     <= rng[17:16];
                rng          <= lcg_step(rng);
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                bmem_ready_o <= 1'b1;
            end
        end else if (wait_cnt != 2'd0) begin
            bmem_rvalid_o <= 1'b0;   // gap between beats
            wait_cnt      <= wait_cnt - 2'd1;
        end else begin
            bmem_rvalid_o <= 1'b1;
            bmem_raddr_o  <= beat_addr;
            // low word at the beat address, high word 4 above it
            bmem_rdata_o  <= {beat_addr + 32'd4, beat_addr} ^ {DATA_KEY, DATA_KEY};
            beat          <= beat + 2'd1;
            wait_cnt      <= rng[17:16];
            rng           <= lcg_step(rng);
            if (beat == 2'd3) busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch;
    localparam int CLK_PERIOD        = 10;
    localparam int RESET_CYCLES      = 5;
    localparam int FIRST_FETCH_LIMIT = 40;
    localparam int FILL_CYCLES       = 80;   // queue fills and a pending refill lands
    localparam int HOLD_CYCLES       = 40;
    localparam int STREAM_LEN        = 40;
    localparam int RESUME_LEN        = 20;
    localparam int REVISIT_LINES     = `ICACHE_SETS / 2;
    localparam int RANDOM_LEN        = 40;
    localparam int TOTAL_ENTRIES     = STREAM_LEN + RESUME_LEN + REVISIT_LINES * 8
                                       + 2 * RANDOM_LEN;
    localparam int WATCHDOG_CYCLES   = 2 * (RESET_CYCLES + FIRST_FETCH_LIMIT + FILL_CYCLES
                                       + HOLD_CYCLES + 12 * TOTAL_ENTRIES);
    localparam logic [31:0] DATA_KEY    = 32'h5A5A_5A5A;
    localparam logic [31:0] REVISIT_PC  = `FETCH_RESET_PC + 32'h40;
    localparam logic [31:0] REVISIT_END = REVISIT_PC + 32'(REVISIT_LINES * 32);
    localparam logic [31:0] FAR_PC      = 32'h0002_0014;   // new region, mid-line

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    redirect;
    logic [31:0]             redirect_pc;
    logic                    deq;
    logic                    valid;
    fetch_pkg::fetch_entry_t entry;
    logic [31:0]             bmem_addr;
    logic                    bmem_read;
    logic                    bmem_ready;
    logic [31:0]             bmem_raddr;
    logic [63:0]             bmem_rdata;
    logic                    bmem_rvalid;

    // reference model state
    logic [31:0] exp_pc;
    logic [63:0] last_order;
    logic        have_order;
    logic        after_redirect;
    logic [31:0] rng;
    logic [31:0] read_addrs [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .deq_i         (deq),
        .valid_o       (valid),
        .entry_o       (entry),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    mem_model i_mem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // every memory read the DUT issues
    always @(posedge clk) begin
        if (!rst && bmem_read) begin
            compare_value("bmem_addr_o[4:0]", 64'(bmem_addr[4:0]), 64'd0);
            read_addrs.push_back(bmem_addr);
        end
    end

    task automatic verify_entry();
        fetch_pkg::fetch_entry_t e;
        e = entry;
        compare_value("entry_o.pc", 64'(e.pc), 64'(exp_pc));
        compare_value("entry_o.inst", 64'(e.inst), 64'(exp_pc ^ DATA_KEY));
        if (after_redirect) begin
            compare_value("entry_o.order > order before redirect",
                          64'(e.order > last_order), 64'd1);
        end else if (have_order) begin
            compare_value("entry_o.order", e.order, last_order + 64'd1);
        end
        last_order     = e.order;
        have_order     = 1'b1;
        after_redirect = 1'b0;
        exp_pc         = exp_pc + 32'd4;
    endtask

    task automatic sample_edge(output logic took);
        @(posedge clk);
        took = valid && deq;
        if (took) verify_entry();
    endtask

    task automatic drain_entries(input int n, input logic random_deq);
        int   got;
        logic took;
        got = 0;
        while (got < n) begin
            if (random_deq) begin
                rng = lcg_step(rng);
                deq <= rng[16];
            end else begin
                deq <= 1'b1;
            end
            sample_edge(took);
            if (took) got++;
        end
    endtask

    task automatic redirect_to(input logic [31:0] target);
        logic took;
        redirect       <= 1'b1;
        redirect_pc    <= target;
        deq            <= 1'b0;   // nothing leaves in the flush cycle
        exp_pc         = target;
        after_redirect = have_order;
        sample_edge(took);
        redirect <= 1'b0;
    endtask

    task automatic reset_and_first_fetch();
        int cycles;
        @(posedge clk);
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            compare_value("valid_o", 64'(valid), 64'd0);
            compare_value("bmem_read_o", 64'(bmem_read), 64'd0);
        end
        rst <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            compare_value("valid_o", 64'(valid), 64'd0);
            cycles++;
            if (cycles > FIRST_FETCH_LIMIT) begin
                $display("no memory read issued after reset");
                stop_on_failure();
            end
        end while (!bmem_read);
        compare_value("bmem_addr_o", 64'(bmem_addr), 64'(`FETCH_RESET_PC & 32'hFFFF_FFE0));
    endtask

    task automatic sequential_stream();
        drain_entries(STREAM_LEN, 1'b0);
    endtask

    task automatic back_pressure();
        logic took;
        int   reads_before;
        deq <= 1'b0;
        repeat (FILL_CYCLES) sample_edge(took);
        reads_before = read_addrs.size();
        repeat (HOLD_CYCLES) begin
            sample_edge(took);
            compare_value("valid_o", 64'(valid), 64'd1);
        end
        compare_value("bmem_read_o count while full", 64'(read_addrs.size()),
                      64'(reads_before));
        drain_entries(RESUME_LEN, 1'b0);   // no gap, no duplicate
    endtask

    task automatic revisit_cached_lines();
        int          first_read;
        logic [31:0] a;
        first_read = read_addrs.size();
        redirect_to(REVISIT_PC);
        drain_entries(REVISIT_LINES * 8, 1'b0);
        for (int i = first_read; i < read_addrs.size(); i++) begin
            a = read_addrs[i];
            compare_value("bmem_read_o to a cached line",
                          64'(a >= REVISIT_PC && a < REVISIT_END), 64'd0);
        end
    endtask

    task automatic random_deq_across_redirect();
        drain_entries(RANDOM_LEN, 1'b1);
        redirect_to(FAR_PC);
        drain_entries(RANDOM_LEN, 1'b1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        stop_on_failure();
    end

    initial begin
        rst            = 1'b1;
        redirect       = 1'b0;
        redirect_pc    = 32'd0;
        deq            = 1'b0;
        exp_pc         = `FETCH_RESET_PC;
        last_order     = 64'd0;
        have_order     = 1'b0;
        after_redirect = 1'b0;
        rng            = 32'd10065;

        reset_and_first_fetch();
        sequential_stream();
        back_pressure();
        revisit_cached_lines();
        random_deq_across_redirect();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch -f src.f -o tb_fetch

./obj_dir/tb_fetch

// File: src.f
+incdir+src
src/fetch_pkg.sv
src/line_if.sv
src/line_refill.sv
src/icache.sv
src/fetch_unit.sv
src/inst_queue.sv
src/fetch_top.sv
bench/mem_model.sv
bench/tb_fetch.sv

// File: src/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC      32'h0000_1000

// instruction queue entries
`define FETCH_QUEUE_DEPTH   8

`define ICACHE_SETS         8   // lines in the direct-mapped icache

`endif

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // eight instruction words
    typedef logic [255:0] cache_line_t;

    typedef logic [26:0] line_addr_t;   // pc[31:5]

    // what decode gets per instruction
    typedef struct packed {
        logic [63:0] order;   // sequence number
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    redirect_i,
    input  logic [31:0]             redirect_pc_i,

    input  logic                    deq_i,
    output logic                    valid_o,
    output fetch_pkg::fetch_entry_t entry_o,

    output logic [31:0]             bmem_addr_o,
    output logic                    bmem_read_o,
    input  logic                    bmem_ready_i,
    input  logic [31:0]             bmem_raddr_i,
    input  logic [63:0]             bmem_rdata_i,
    input  logic                    bmem_rvalid_i
);
    import fetch_pkg::*;

    line_if fetch_ic ();    // fetch_unit -> icache
    line_if ic_refill ();   // icache -> line_refill

    logic         enq;
    fetch_entry_t enq_entry;
    logic         q_full;
    logic         q_empty;

    assign valid_o = !q_empty;

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .ic            (fetch_ic.requester),
        .enq_o         (enq),
        .enq_entry_o   (enq_entry),
        .full_i        (q_full)
    );

    icache i_icache (
        .clk (clk),
        .rst (rst),
        .up  (fetch_ic.server),
        .dn  (ic_refill.requester)
    );

    line_refill i_line_refill (
        .clk           (clk),
        .rst           (rst),
        .up            (ic_refill.server),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    inst_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) i_inst_queue (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect_i),
        .enq_i   (enq),
        .entry_i (enq_entry),
        .full_o  (q_full),
        .deq_i   (deq_i),
        .entry_o (entry_o),
        .empty_o (q_empty)
    );

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_i,
    input  logic [31:0]             redirect_pc_i,
    line_if.requester               ic,
    output logic                    enq_o,
    output fetch_pkg::fetch_entry_t enq_entry_o,
    input  logic                    full_i
);
    import fetch_pkg::*;

    logic [31:0] pc;
    logic [63:0] order;
    cache_line_t buf_line;   // line buffer
    line_addr_t  buf_addr;
    logic        buf_valid;
    logic        req_q;
    line_addr_t  req_addr_q;
    logic        buf_hit;
    logic        keep_resp;
    logic [31:0] word;

    assign buf_hit = buf_valid && (buf_addr == pc[31:5]);
    assign word    = buf_line[pc[4:2]*32 +: 32];
    assign enq_o   = buf_hit && !full_i;

    assign enq_entry_o = '{order: order, pc: pc, inst: word};

    // stale line after a redirect is dropped
    assign keep_resp = req_q && ic.resp && !redirect_i && (req_addr_q == pc[31:5]);

    assign ic.req  = req_q;
    assign ic.addr = req_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= `FETCH_RESET_PC;
            order     <= 64'd0;
            buf_valid <= 1'b0;
            req_q     <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (enq_o) begin
                pc <= pc + 32'd4;
            end
            if (enq_o) order <= order + 64'd1;   // flushed entries count too

            if (req_q) begin
                if (ic.resp) req_q <= 1'b0;
            end else if (!buf_hit && !redirect_i) begin
                req_q <= 1'b1;
            end
            if (keep_resp) buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!req_q) req_addr_q <= pc[31:5];   // frozen while req is up
        if (keep_resp) begin
            buf_line <= ic.line;
            buf_addr <= req_addr_q;
        end
    end

    // icache answers only an open request
    a_resp_while_req: assert property (
        @(posedge clk) disable iff (rst) ic.resp |-> req_q
    );

endmodule

`default_nettype wire

// File: src/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module icache (
    input  logic        clk,
    input  logic        rst,
    line_if.server      up,     // from fetch
    line_if.requester   dn      // to refill
);
    import fetch_pkg::*;

    localparam int SETS  = `ICACHE_SETS;
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = $bits(line_addr_t) - IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS,
        S_RESP
    } state_t;

    state_t             state;
    cache_line_t        data_arr [SETS];
    logic [TAG_W-1:0]   tag_arr  [SETS];
    logic [SETS-1:0]    valid_arr;
    cache_line_t        line_q;
    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;

    assign idx = up.addr[IDX_W-1:0];
    assign tag = up.addr[$bits(line_addr_t)-1:IDX_W];
    assign hit = valid_arr[idx] && (tag_arr[idx] == tag);

    assign up.line = line_q;
    assign up.resp = (state == S_RESP);
    assign dn.req  = (state == S_MISS);
    assign dn.addr = up.addr;   // requester holds addr through the miss

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            valid_arr <= '0;
            for (int i = 0; i < SETS; i++) begin
                tag_arr[i] <= '0;
            end
        end else begin
            case (state)
                S_IDLE: begin
                    if (up.req) state <= hit ? S_RESP : S_MISS;
                end
                S_MISS: begin
                    if (dn.resp) begin
                        valid_arr[idx] <= 1'b1;
                        tag_arr[idx]   <= tag;
                        state          <= S_RESP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && up.req && hit) line_q <= data_arr[idx];
        if (state == S_MISS && dn.resp) begin
            data_arr[idx] <= dn.line;
            line_q        <= dn.line;   // answer with the fresh line
        end
    end

    // refill only answers a miss we asked for
    a_refill_resp_on_miss: assert property (
        @(posedge clk) disable iff (rst) dn.resp |-> state == S_MISS
    );

endmodule

`default_nettype wire

// File: src/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    enq_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    output logic                    full_o,
    input  logic                    deq_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    empty_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    fetch_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    assign full_o  = (count == FULL_CNT);
    assign empty_o = (count == '0);
    assign entry_o = mem[rd_ptr];
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_deq) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) mem[wr_ptr] <= entry_i;   // slot is dead anyway on flush
    end

endmodule

`default_nettype wire

// File: src/line_if.sv
`timescale 1ns/1ps
`default_nettype none

// line request from requester, line plus resp pulse back from server
interface line_if;
    import fetch_pkg::*;

    logic        req;
    line_addr_t  addr;
    cache_line_t line;
    logic        resp;

    // req and addr held until resp
    modport requester (
        output req,
        output addr,
        input  line,
        input  resp
    );

    modport server (
        input  req,
        input  addr,
        output line,
        output resp
    );

endinterface

`default_nettype wire

// File: src/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill (
    input  logic         clk,
    input  logic         rst,
    line_if.server       up,
    output logic [31:0]  bmem_addr_o,
    output logic         bmem_read_o,
    input  logic         bmem_ready_i,
    input  logic [31:0]  bmem_raddr_i,
    input  logic [63:0]  bmem_rdata_i,
    input  logic         bmem_rvalid_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_BEATS,
        S_DONE
    } state_t;

    state_t      state;
    logic [1:0]  beat_cnt;
    line_addr_t  addr_q;
    cache_line_t line_q;

    assign bmem_addr_o = {addr_q, 5'b0};
    assign bmem_read_o = (state == S_ISSUE) && bmem_ready_i;   // one-cycle strobe
    assign up.line     = line_q;
    assign up.resp     = (state == S_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            beat_cnt <= 2'd0;
        end else begin
            case (state)
                S_IDLE: if (up.req) state <= S_ISSUE;
                S_ISSUE: begin
                    if (bmem_ready_i) begin
                        state    <= S_BEATS;
                        beat_cnt <= 2'd0;
                    end
                end
                S_BEATS: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (beat_cnt == 2'd3) state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;   // resp cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) addr_q <= up.addr;
        // beats placed by their own address
        if (state == S_BEATS && bmem_rvalid_i) begin
            line_q[bmem_raddr_i[4:3]*64 +: 64] <= bmem_rdata_i;
        end
    end

    // memory must not return data unless a read was issued
    a_rvalid_outstanding: assert property (
        @(posedge clk) disable iff (rst) bmem_rvalid_i |-> state == S_BEATS
    );

endmodule

`default_nettype wire
